// ==== logic/mbus_pkg.sv ====
/*
 * Main bus map definitions
 * Widths, request struct, region and state encodings, address constants
 */
`default_nettype none

package mbus_pkg;

	// Bus widths
	typedef logic [22:0] word_addr_t;
	typedef logic [15:0] data_t;
	typedef logic [1:0]  byte_en_t;
	typedef logic [23:0] rom_words_t;
	typedef logic [4:0]  bank_t;

	// One captured master request
	typedef struct packed {
		word_addr_t addr;
		data_t      wdata;
		logic       rnw;
		byte_en_t   be;
	} mbus_req_t;

	typedef enum logic [2:0] {
		TGT_ROM,
		TGT_SRAM,
		TGT_WRAM,
		TGT_BANK,
		TGT_ZERO,
		TGT_OPEN
	} target_e;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_SELECT,
		SEQ_MEM,
		SEQ_ROM,
		SEQ_FINISH
	} seq_state_e;

	localparam data_t      OPEN_BUS_INIT        = 16'h4E71;
	localparam rom_words_t BANK_THRESHOLD_WORDS = 24'h100000;
	localparam int         BANK_REG_COUNT       = 8;

	// Word addresses, byte address shifted right by one
	localparam word_addr_t ROM_WINDOW_END_W = 23'h500000;
	localparam word_addr_t SRAM_BASE_W      = 23'h100000;
	localparam word_addr_t SRAM_END_W       = 23'h1C0000;
	localparam word_addr_t SRAM_OVR_END_W   = 23'h200000;
	localparam logic [15:0] BANK_PAGE       = 16'hA130;
	localparam word_addr_t WRAM_BASE_W      = 23'h700000;

endpackage

`default_nettype wire

// ==== logic/mbus_decoder.sv ====
/*
 * Main bus address decoder
 * Classifies the captured request into one target region
 */
`default_nettype none

module mbus_decoder (
	input  wire mbus_pkg::mbus_req_t  cur_req,
	input  wire                       bank_sram,
	input  wire mbus_pkg::rom_words_t rom_size,
	output mbus_pkg::target_e         target
);

	logic in_rom_window;
	logic in_rom_image;
	logic in_sram;
	logic in_sram_ovr;
	logic in_bank_page;
	logic in_wram;

	// Region compares on the word address
	assign in_rom_window = cur_req.addr < mbus_pkg::ROM_WINDOW_END_W;
	assign in_rom_image  = {1'b0, cur_req.addr} < rom_size;
	assign in_sram       = cur_req.addr >= mbus_pkg::SRAM_BASE_W &&
	                       cur_req.addr < mbus_pkg::SRAM_END_W;
	assign in_sram_ovr   = cur_req.addr >= mbus_pkg::SRAM_BASE_W &&
	                       cur_req.addr < mbus_pkg::SRAM_OVR_END_W;
	assign in_bank_page  = cur_req.addr[22:7] == mbus_pkg::BANK_PAGE;
	assign in_wram       = cur_req.addr >= mbus_pkg::WRAM_BASE_W;

	always_comb begin
		if (in_rom_window) begin
			// Enabled save RAM wins over the ROM image
			if (bank_sram && in_sram_ovr)
				target = mbus_pkg::TGT_SRAM;
			else if (!cur_req.rnw)
				target = mbus_pkg::TGT_ZERO;
			else if (in_rom_image)
				target = mbus_pkg::TGT_ROM;
			else if (in_sram)
				target = mbus_pkg::TGT_SRAM;
			else
				target = mbus_pkg::TGT_ZERO;
		end else if (in_bank_page) begin
			target = cur_req.rnw ? mbus_pkg::TGT_OPEN : mbus_pkg::TGT_BANK;
		end else if (in_wram) begin
			target = mbus_pkg::TGT_WRAM;
		end else begin
			target = mbus_pkg::TGT_OPEN;
		end
	end

endmodule

`default_nettype wire

// ==== logic/cart_bank_regs.sv ====
/*
 * Cartridge mapper registers
 * Bank select, save RAM enable and ROM address translation
 */
`default_nettype none

module cart_bank_regs (
	input  wire                       MCLK,
	input  wire                       reset,
	input  wire mbus_pkg::mbus_req_t  cur_req,
	input  wire                       bank_wr,
	input  wire mbus_pkg::rom_words_t rom_size,
	output logic                      bank_sram,
	output mbus_pkg::word_addr_t      rom_addr
);

	mbus_pkg::bank_t bank_reg [mbus_pkg::BANK_REG_COUNT];
	logic            bank_rom;
	logic            large_rom;
	logic [2:0]      reg_idx;

	assign large_rom = rom_size > mbus_pkg::BANK_THRESHOLD_WORDS;
	assign reg_idx   = cur_req.addr[2:0];

	always_ff @(posedge MCLK) begin
		if (reset) begin
			bank_rom  <= 1'b0;
			bank_sram <= 1'b0;
			// Identity mapping out of reset
			for (int i = 0; i < mbus_pkg::BANK_REG_COUNT; i++)
				bank_reg[i] <= mbus_pkg::bank_t'(i);
		end else if (bank_wr) begin
			if (large_rom && reg_idx != 3'd0) begin
				bank_rom          <= 1'b1;
				bank_reg[reg_idx] <= cur_req.wdata[4:0];
			end else begin
				// Index 0, or any index on small carts
				bank_sram <= cur_req.wdata[0];
			end
		end
	end

	// 512 KB windows picked by bits 20:18 of the word address
	assign rom_addr = bank_rom ? {bank_reg[cur_req.addr[20:18]], cur_req.addr[17:0]}
	                           : cur_req.addr;

endmodule

`default_nettype wire

// ==== logic/work_ram.sv ====
/*
 * Work RAM, 32K x 16
 * Per-byte write enables and a registered read port
 */
`default_nettype none

module work_ram (
	input  wire                     MCLK,
	input  wire [14:0]              addr,
	input  wire mbus_pkg::data_t    wdata,
	input  wire mbus_pkg::byte_en_t we,
	output mbus_pkg::data_t         q
);

	mbus_pkg::data_t mem [32768];

	always_ff @(posedge MCLK) begin
		// Upper and lower byte lanes
		if (we[1])
			mem[addr][15:8] <= wdata[15:8];
		if (we[0])
			mem[addr][7:0] <= wdata[7:0];
		q <= mem[addr];
	end

endmodule

`default_nettype wire

// ==== logic/save_ram.sv ====
/*
 * Save RAM, 64K x 8 with a registered read
 */
`default_nettype none

module save_ram (
	input  wire        MCLK,
	input  wire [15:0] addr,
	input  wire [7:0]  wdata,
	input  wire        we,
	output logic [7:0] q
);

	logic [7:0] mem [65536];

	always_ff @(posedge MCLK) begin
		if (we)
			mem[addr] <= wdata;
		q <= mem[addr];
	end

endmodule

`default_nettype wire

// ==== logic/mbus_sequencer.sv ====
/*
 * Main bus sequencer
 * Runs one transaction at a time from request capture to response handshake
 */
`default_nettype none

module mbus_sequencer (
	input  wire                      MCLK,
	input  wire                      reset,
	input  wire mbus_pkg::mbus_req_t req,
	input  wire                      req_valid,
	output logic                     req_ready,
	output mbus_pkg::data_t          rsp_data,
	output logic                     rsp_valid,
	input  wire                      rsp_ready,
	output mbus_pkg::mbus_req_t      cur_req,
	input  wire mbus_pkg::target_e   target,
	output logic                     bank_wr,
	output mbus_pkg::byte_en_t       wram_we,
	output logic                     sram_we,
	input  wire mbus_pkg::data_t     wram_q,
	input  wire [7:0]                sram_q,
	output logic                     rom_req,
	input  wire                      rom_ack,
	input  wire mbus_pkg::data_t     rom_data
);

	mbus_pkg::seq_state_e state;
	mbus_pkg::data_t      open_bus;
	mbus_pkg::data_t      mem_rdata;
	logic                 is_write;
	logic                 rom_done;

	assign is_write  = ~cur_req.rnw;
	assign rom_done  = (rom_ack == rom_req);
	assign req_ready = (state == mbus_pkg::SEQ_IDLE);
	assign rsp_valid = (state == mbus_pkg::SEQ_FINISH);

	// Save RAM byte shows up in both halves
	assign mem_rdata = (target == mbus_pkg::TGT_SRAM) ? {sram_q, sram_q} : wram_q;

	// Write strobes fire in the select cycle only
	always_comb begin
		bank_wr = 1'b0;
		wram_we = '0;
		sram_we = 1'b0;
		if (state == mbus_pkg::SEQ_SELECT && is_write) begin
			case (target)
				mbus_pkg::TGT_WRAM: wram_we = cur_req.be;
				mbus_pkg::TGT_SRAM: sram_we = 1'b1;
				mbus_pkg::TGT_BANK: bank_wr = 1'b1;
				default: ;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Bus FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state    <= mbus_pkg::SEQ_IDLE;
			open_bus <= mbus_pkg::OPEN_BUS_INIT;
			rom_req  <= 1'b0;
		end else begin
			case (state)
				mbus_pkg::SEQ_IDLE: begin
					if (req_valid)
						state <= mbus_pkg::SEQ_SELECT;
				end
				mbus_pkg::SEQ_SELECT: begin
					case (target)
						mbus_pkg::TGT_ROM: begin
							// Toggle starts the external read
							rom_req <= ~rom_req;
							state   <= mbus_pkg::SEQ_ROM;
						end
						mbus_pkg::TGT_WRAM, mbus_pkg::TGT_SRAM: begin
							if (is_write)
								state <= mbus_pkg::SEQ_FINISH;
							else
								state <= mbus_pkg::SEQ_MEM;
						end
						default: state <= mbus_pkg::SEQ_FINISH;
					endcase
				end
				mbus_pkg::SEQ_MEM: begin
					open_bus <= mem_rdata;
					state    <= mbus_pkg::SEQ_FINISH;
				end
				mbus_pkg::SEQ_ROM: begin
					if (rom_done) begin
						open_bus <= rom_data;
						state    <= mbus_pkg::SEQ_FINISH;
					end
				end
				mbus_pkg::SEQ_FINISH: begin
					// Held here while the master stalls
					if (rsp_ready)
						state <= mbus_pkg::SEQ_IDLE;
				end
				default: state <= mbus_pkg::SEQ_IDLE;
			endcase
		end
	end

	// Request capture and response data
	always_ff @(posedge MCLK) begin
		if (req_valid && req_ready)
			cur_req <= req;
		case (state)
			mbus_pkg::SEQ_SELECT: begin
				if (target == mbus_pkg::TGT_ZERO)
					rsp_data <= '0;
				else if (target == mbus_pkg::TGT_OPEN)
					rsp_data <= open_bus;
			end
			mbus_pkg::SEQ_MEM: rsp_data <= mem_rdata;
			mbus_pkg::SEQ_ROM: begin
				if (rom_done)
					rsp_data <= rom_data;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/mbus_system.sv ====
/*
 * Main bus controller top level
 * Connects the sequencer, address decoder, mapper and the two RAMs
 */
`default_nettype none

module mbus_system (
	input  wire                       MCLK,
	input  wire                       reset,
	input  wire mbus_pkg::mbus_req_t  req,
	input  wire                       req_valid,
	output logic                      req_ready,
	output mbus_pkg::data_t           rsp_data,
	output logic                      rsp_valid,
	input  wire                       rsp_ready,
	input  wire mbus_pkg::rom_words_t rom_size,
	output mbus_pkg::word_addr_t      rom_addr,
	output logic                      rom_req,
	input  wire                       rom_ack,
	input  wire mbus_pkg::data_t      rom_data
);

	mbus_pkg::mbus_req_t cur_req;
	mbus_pkg::target_e   target;
	logic                bank_wr;
	logic                bank_sram;
	mbus_pkg::byte_en_t  wram_we;
	logic                sram_we;
	mbus_pkg::data_t     wram_q;
	logic [7:0]          sram_q;

	mbus_sequencer u_seq (
		.MCLK      (MCLK),
		.reset     (reset),
		.req       (req),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.rsp_data  (rsp_data),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.cur_req   (cur_req),
		.target    (target),
		.bank_wr   (bank_wr),
		.wram_we   (wram_we),
		.sram_we   (sram_we),
		.wram_q    (wram_q),
		.sram_q    (sram_q),
		.rom_req   (rom_req),
		.rom_ack   (rom_ack),
		.rom_data  (rom_data)
	);

	mbus_decoder u_dec (
		.cur_req   (cur_req),
		.bank_sram (bank_sram),
		.rom_size  (rom_size),
		.target    (target)
	);

	cart_bank_regs u_bank (
		.MCLK      (MCLK),
		.reset     (reset),
		.cur_req   (cur_req),
		.bank_wr   (bank_wr),
		.rom_size  (rom_size),
		.bank_sram (bank_sram),
		.rom_addr  (rom_addr)
	);

	// 64 KB work RAM mirrored over E00000 and up
	work_ram u_wram (
		.MCLK  (MCLK),
		.addr  (cur_req.addr[14:0]),
		.wdata (cur_req.wdata),
		.we    (wram_we),
		.q     (wram_q)
	);

	save_ram u_sram (
		.MCLK  (MCLK),
		.addr  (cur_req.addr[15:0]),
		.wdata (cur_req.wdata[7:0]),
		.we    (sram_we),
		.q     (sram_q)
	);

endmodule

`default_nettype wire

// ==== bench/mbus_assertions.sv ====
/*
 * Bus sequencer handshake checks
 * Response hold, request reopening and ROM toggle protocol
 */
`default_nettype none

module mbus_assertions (
	input wire                  MCLK,
	input wire                  reset,
	input wire                  req_ready,
	input wire                  rsp_valid,
	input wire                  rsp_ready,
	input wire mbus_pkg::data_t rsp_data,
	input wire                  rom_req,
	input wire                  rom_ack
);

	// Response held while the master stalls
	rsp_hold: assert property (@(posedge MCLK) disable iff (reset)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
		else $error("response changed before rsp_ready");

	// Request channel reopens only once the response was taken
	req_after_rsp: assert property (@(posedge MCLK) disable iff (reset)
		$rose(req_ready) |-> $past(rsp_valid && rsp_ready))
		else $error("req_ready rose without a response handshake");

	// A new ROM toggle only once the last one was answered
	rom_toggle: assert property (@(posedge MCLK) disable iff (reset)
		(rom_req != $past(rom_req)) |-> ($past(rom_req) == $past(rom_ack)))
		else $error("rom_req toggled while a ROM read was pending");

endmodule

bind mbus_sequencer mbus_assertions u_handshake_chk (
	.MCLK      (MCLK),
	.reset     (reset),
	.req_ready (req_ready),
	.rsp_valid (rsp_valid),
	.rsp_ready (rsp_ready),
	.rsp_data  (rsp_data),
	.rom_req   (rom_req),
	.rom_ack   (rom_ack)
);

`default_nettype wire

// ==== bench/mbus_tb.sv ====
/*
 * Main bus controller testbench
 * Random traffic over all regions, checked against a reference model
 */
`default_nettype none

module mbus_tb;

	localparam int          WAIT_LIMIT = 200;
	localparam logic [31:0] SEED       = 32'h6bbf_4ef9;

	logic                 MCLK = 1'b0;
	logic                 reset;
	mbus_pkg::mbus_req_t  req;
	logic                 req_valid;
	logic                 req_ready;
	mbus_pkg::data_t      rsp_data;
	logic                 rsp_valid;
	logic                 rsp_ready;
	mbus_pkg::rom_words_t rom_size;
	mbus_pkg::word_addr_t rom_addr;
	logic                 rom_req;
	logic                 rom_ack = 1'b0;
	mbus_pkg::data_t      rom_data = '0;

	// Reference model state
	mbus_pkg::data_t      wram_m [32768];
	logic [7:0]           sram_m [65536];
	mbus_pkg::bank_t      bank_m [8];
	logic                 bank_sram_m;
	logic                 bank_rom_m;
	mbus_pkg::data_t      open_m;

	logic [31:0]          rng;
	logic [31:0]          rom_rng = SEED;
	logic                 rom_busy = 1'b0;
	logic [2:0]           rom_delay;
	mbus_pkg::word_addr_t rom_seen_addr;
	logic                 bp;
	logic                 hung;
	int                   errors;
	int                   issued;
	int                   req_count = 0;
	int                   rsp_count = 0;

	mbus_system uut (
		.MCLK      (MCLK),
		.reset     (reset),
		.req       (req),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.rsp_data  (rsp_data),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rom_size  (rom_size),
		.rom_addr  (rom_addr),
		.rom_req   (rom_req),
		.rom_ack   (rom_ack),
		.rom_data  (rom_data)
	);

	always #10 MCLK = ~MCLK;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			rng = lfsr_next(rng);
			v = {v[30:0], rng[0]};
		end
	endtask

	// ------------------------------------------------------------------------
	// ROM responder, answers after 0 to 7 cycles
	// ------------------------------------------------------------------------
	always @(posedge MCLK) begin
		if (reset) begin
			rom_ack <= 1'b0;
			rom_busy = 1'b0;
		end else if (!rom_busy && rom_req != rom_ack) begin
			rom_busy = 1'b1;
			rom_seen_addr = rom_addr;
			rom_delay = '0;
			for (int b = 0; b < 3; b++) begin
				rom_rng = lfsr_next(rom_rng);
				rom_delay = {rom_delay[1:0], rom_rng[0]};
			end
		end else if (rom_busy) begin
			if (rom_delay == 3'd0) begin
				rom_data <= rom_seen_addr[15:0] ^ 16'h5A3C;
				rom_ack  <= rom_req;
				rom_busy = 1'b0;
			end else begin
				rom_delay = rom_delay - 3'd1;
			end
		end
	end

	// Handshake counters for lost or doubled transfers
	always @(posedge MCLK) begin
		if (!reset && req_valid && req_ready)
			req_count = req_count + 1;
		if (!reset && rsp_valid && rsp_ready)
			rsp_count = rsp_count + 1;
	end

	task automatic report_timeout(input string what);
		$display("Timeout at time %0t: %s", $time, what);
		errors++;
		hung = 1'b1;
	endtask

	// Model of one access; exp is valid only when check is set
	task automatic model_access(input mbus_pkg::mbus_req_t r, output logic check,
			output mbus_pkg::data_t exp, output logic is_rom,
			output mbus_pkg::word_addr_t xlat);
		logic [23:0] b;
		logic        to_sram;
		b = {r.addr, 1'b0};
		check = r.rnw;
		exp = '0;
		is_rom = 1'b0;
		to_sram = 1'b0;
		xlat = bank_rom_m ? {bank_m[r.addr[20:18]], r.addr[17:0]} : r.addr;
		if (b < 24'hA00000) begin
			if (bank_sram_m && b >= 24'h200000 && b < 24'h400000)
				to_sram = 1'b1;
			else if (!r.rnw)
				check = 1'b0;
			else if ({1'b0, r.addr} < rom_size) begin
				is_rom = 1'b1;
				exp = xlat[15:0] ^ 16'h5A3C;
				open_m = exp;
			end else if (b >= 24'h200000 && b < 24'h380000)
				to_sram = 1'b1;
		end else if (b[23:8] == 16'hA130) begin
			if (r.rnw)
				exp = open_m;
			else if (rom_size > 24'h100000 && r.addr[2:0] != 3'd0) begin
				bank_rom_m = 1'b1;
				bank_m[r.addr[2:0]] = r.wdata[4:0];
			end else
				bank_sram_m = r.wdata[0];
		end else if (b >= 24'hE00000) begin
			if (r.rnw) begin
				exp = wram_m[r.addr[14:0]];
				open_m = exp;
			end else begin
				if (r.be[1])
					wram_m[r.addr[14:0]][15:8] = r.wdata[15:8];
				if (r.be[0])
					wram_m[r.addr[14:0]][7:0] = r.wdata[7:0];
			end
		end else if (r.rnw)
			exp = open_m;
		if (to_sram) begin
			if (r.rnw) begin
				exp = {sram_m[r.addr[15:0]], sram_m[r.addr[15:0]]};
				open_m = exp;
			end else
				sram_m[r.addr[15:0]] = r.wdata[7:0];
		end
	endtask

	// One transfer through both channels, then compared with the model
	task automatic bus_access(input mbus_pkg::word_addr_t a, input mbus_pkg::data_t wd,
			input logic rnw, input mbus_pkg::byte_en_t be);
		mbus_pkg::mbus_req_t  r;
		logic                 check;
		logic                 is_rom;
		mbus_pkg::data_t      exp;
		mbus_pkg::word_addr_t xlat;
		logic [31:0]          v;
		int                   n;
		if (hung)
			return;
		r = '{addr: a, wdata: wd, rnw: rnw, be: be};
		model_access(r, check, exp, is_rom, xlat);
		req       <= r;
		req_valid <= 1'b1;
		n = 0;
		do begin
			@(posedge MCLK);
			n++;
		end while (!req_ready && n < WAIT_LIMIT);
		if (!req_ready) begin
			report_timeout("request was never accepted");
			return;
		end
		req_valid <= 1'b0;
		issued++;
		n = 0;
		do begin
			if (bp) begin
				take_bits(1, v);
				rsp_ready <= v[0];
			end else
				rsp_ready <= 1'b1;
			@(posedge MCLK);
			n++;
		end while (!(rsp_valid && rsp_ready) && n < WAIT_LIMIT);
		if (!(rsp_valid && rsp_ready)) begin
			report_timeout("no response for an accepted request");
			return;
		end
		if (check && rsp_data !== exp) begin
			$display("** Error @ %0t: addr %h read %h, expected %h", $time, a, rsp_data, exp);
			errors++;
		end
		if (is_rom && rom_seen_addr !== xlat) begin
			$display("** Error @ %0t: addr %h gave ROM address %h, expected %h",
				$time, a, rom_seen_addr, xlat);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		$display("%s: %s (%0d errors)", name, (errors == err_before) ? "passed" : "failed",
			errors - err_before);
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------
	initial begin
		logic [31:0] v;
		logic [31:0] w;
		int          e;
		reset     = 1'b1;
		req       = '0;
		req_valid = 1'b0;
		rsp_ready = 1'b1;
		rom_size  = 24'h080000;
		rng       = SEED;
		bp        = 1'b0;
		hung      = 1'b0;
		errors    = 0;
		issued    = 0;
		bank_sram_m = 1'b0;
		bank_rom_m  = 1'b0;
		open_m      = 16'h4E71;
		for (int i = 0; i < 8; i++)
			bank_m[i] = 5'(i);
		repeat (8) @(posedge MCLK);
		reset <= 1'b0;
		@(posedge MCLK);

		// Open bus first, while it still holds the reset value
		e = errors;
		bus_access(23'h600000, 16'h0000, 1'b1, 2'b11);
		bus_access(23'h700010, 16'hC3A5, 1'b0, 2'b11);
		bus_access(23'h700010, 16'h0000, 1'b1, 2'b11);
		bus_access(23'h600002, 16'h0000, 1'b1, 2'b11);
		bus_access(23'h600004, 16'h1234, 1'b0, 2'b11);
		bus_access(23'h500100, 16'h0000, 1'b1, 2'b11);
		end_test("open bus", e);

		e = errors;
		for (int k = 0; k < 64; k++) begin
			take_bits(16, w);
			bus_access({3'b111, 5'd0, 9'd0, 6'(k)}, w[15:0], 1'b0, 2'b11);
		end
		for (int i = 0; i < 100; i++) begin
			take_bits(14, v);
			take_bits(16, w);
			bus_access({3'b111, v[4:0], 9'd0, v[10:5]}, w[15:0], v[11], v[13:12]);
		end
		end_test("work RAM", e);

		e = errors;
		for (int i = 0; i < 40; i++) begin
			take_bits(19, v);
			bus_access({4'd0, v[18:0]}, 16'h0000, 1'b1, 2'b11);
		end
		for (int i = 0; i < 20; i++) begin
			take_bits(20, v);
			if (v[19])
				bus_access(23'h080000 | {4'd0, v[18:0]}, 16'h0000, 1'b1, 2'b11);
			else
				bus_access(23'h400000 | {4'd0, v[18:0]}, 16'h0000, 1'b1, 2'b11);
		end
		end_test("ROM small", e);

		// Save RAM is filled through the override, then read without it
		e = errors;
		bus_access(23'h509800, 16'h0001, 1'b0, 2'b11);
		for (int k = 0; k < 64; k++) begin
			take_bits(16, w);
			bus_access({2'b00, 1'b1, 14'd0, 6'(k)}, w[15:0], 1'b0, 2'b01);
		end
		bus_access(23'h509800, 16'h0000, 1'b0, 2'b11);
		for (int i = 0; i < 60; i++) begin
			take_bits(10, v);
			bus_access({2'b00, 1'b1, v[2:0], 11'd0, v[8:3]}, 16'h00A5, v[9] | v[0], 2'b01);
		end
		end_test("save RAM", e);

		e = errors;
		rom_size <= 24'h200000;
		// New size in place before the first bank write
		@(posedge MCLK);
		for (int i = 1; i < 8; i++) begin
			take_bits(16, w);
			bus_access(23'h509800 | 23'(i), w[15:0], 1'b0, 2'b11);
		end
		for (int i = 0; i < 40; i++) begin
			take_bits(21, v);
			bus_access({2'b00, v[20:0]}, 16'h0000, 1'b1, 2'b11);
		end
		take_bits(7, v);
		bus_access({16'hA130, v[6:0]}, 16'h0000, 1'b1, 2'b11);
		bus_access(23'h509800, 16'h0001, 1'b0, 2'b11);
		for (int i = 0; i < 30; i++) begin
			take_bits(21, v);
			if (v[20])
				bus_access({2'b00, 1'b1, v[3:0], 10'd0, v[9:4]}, 16'h0000, 1'b1, 2'b11);
			else
				bus_access({3'b000, v[19:0]}, 16'h0000, 1'b1, 2'b11);
		end
		end_test("banking", e);

		e = errors;
		bp = 1'b1;
		for (int i = 0; i < 80; i++) begin
			take_bits(2, v);
			take_bits(20, w);
			case (v[1:0])
				2'd0: bus_access({3'b111, w[4:0], 9'd0, w[10:5]}, w[19:4], w[11], w[13:12]);
				2'd1: bus_access({2'b00, 1'b1, w[3:0], 10'd0, w[9:4]}, w[19:4], w[10], 2'b01);
				2'd2: bus_access({3'b000, w[19:0]}, 16'h0000, 1'b1, 2'b11);
				default: bus_access(23'h600000 | {15'd0, w[7:0]}, w[19:4], w[8], 2'b11);
			endcase
		end
		bp = 1'b0;
		@(posedge MCLK);
		if (req_count != issued || rsp_count != issued) begin
			$display("Transfer count mismatch: %0d issued, %0d accepted, %0d answered",
				issued, req_count, rsp_count);
			errors++;
		end
		end_test("back-pressure", e);

		$display("Transfers %0d, errors %0d", issued, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mbus_map.f ====
logic/mbus_pkg.sv
logic/mbus_decoder.sv
logic/cart_bank_regs.sv
logic/work_ram.sv
logic/save_ram.sv
logic/mbus_sequencer.sv
logic/mbus_system.sv
bench/mbus_assertions.sv
bench/mbus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the mbus_map simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mbus_map.f --top-module mbus_tb -o mbus_sim \
	> build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/mbus_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test FAILED" sim.log; then
	exit 1
fi
exit 0
